// File: logic/dmi_pkg.sv
// ======================================================================
// Debug module interface definitions for the system bus loader
//   DMI register address type and the addresses in use
//   SBCS field layout, access size and error codes
//   Union giving a raw and an SBCS view of one DMI data word
// ======================================================================

package dmi_pkg;

   localparam int DMI_DATA_W = 32;

   typedef logic [6:0] dmi_addr_t;

   localparam dmi_addr_t DMI_SBCS       = 7'h38;
   localparam dmi_addr_t DMI_SBADDRESS0 = 7'h39;
   localparam dmi_addr_t DMI_SBDATA0    = 7'h3C;

   localparam logic [2:0] SBCS_VERSION = 3'd1;
   localparam logic [2:0] SBACCESS_32  = 3'd2;
   localparam logic [2:0] SBERR_SIZE   = 3'd4;

   // System bus control and status, MSB first
   typedef struct packed {
      logic [2:0] sbversion;
      logic [5:0] rsvd;
      logic       sbbusyerror;
      logic       sbbusy;
      logic       sbreadonaddr;
      logic [2:0] sbaccess;
      logic       sbautoincrement;
      logic       sbreadondata;
      logic [2:0] sberror;
      logic [6:0] sbasize;
      logic       sbaccess128;
      logic       sbaccess64;
      logic       sbaccess32;
      logic       sbaccess16;
      logic       sbaccess8;
   } sbcs_t;

   typedef union packed {
      logic [DMI_DATA_W-1:0] raw;
      sbcs_t                 sbcs;
   } dmi_word_u;

endpackage

// File: logic/sba_pkg.sv
// ======================================================================
// System bus side definitions
//   Address and data widths of the memory write port
//   Queue depth, pointer and occupancy widths
//   Queued write entry
// ======================================================================

package sba_pkg;

   localparam int SBA_ADDR_W = 32;
   localparam int SBA_DATA_W = 32;

   typedef logic [SBA_ADDR_W-1:0] sba_addr_t;
   typedef logic [SBA_DATA_W-1:0] sba_data_t;

   localparam int SBA_FIFO_DEPTH = 4;
   localparam int SBA_PTR_W      = $clog2(SBA_FIFO_DEPTH);
   // Needs to hold the value 4 itself
   localparam int SBA_CNT_W      = $clog2(SBA_FIFO_DEPTH + 1);

   // Byte step between consecutive words
   localparam sba_addr_t SBA_ADDR_STEP = 32'd4;

   typedef struct packed {
      sba_addr_t addr;
      sba_data_t data;
   } sba_entry_t;

endpackage

// File: logic/sba_push_if.sv
// ======================================================================
// Push side of the write queue
//   Single-cycle push strobe with the entry to store
//   Full and empty flags returned to the register block
// ======================================================================

`timescale 1ns/1ps

interface sba_push_if;

   logic                push;
   sba_pkg::sba_entry_t entry;
   logic                full;
   logic                empty;

   modport producer (
      output push,
      output entry,
      input  full,
      input  empty
   );

   modport buffer (
      input  push,
      input  entry,
      output full,
      output empty
   );

endinterface

// File: logic/sba_pop_if.sv
// ======================================================================
// Pop side of the write queue
//   Head entry and empty flag towards the memory writer
//   Single-cycle pop strobe back to the queue
// ======================================================================

`timescale 1ns/1ps

interface sba_pop_if;

   logic                pop;
   sba_pkg::sba_entry_t head;
   logic                empty;

   modport buffer (
      input  pop,
      output head,
      output empty
   );

   modport consumer (
      output pop,
      input  head,
      input  empty
   );

endinterface

// File: logic/dmi_regs.sv
// ======================================================================
// DMI register block of the system bus loader
//   Request capture stage and one-cycle read response
//   SBCS control and sticky error fields, SBAddress0 counter
//   SBData0 writes pushed into the write queue
// ======================================================================

`timescale 1ns/1ps

module dmi_regs (
   input  logic                           clk_sys,
   input  logic                           rst_n_i,
   input  logic                           dmi_req_i,
   input  logic                           dmi_we_i,
   input  dmi_pkg::dmi_addr_t             dmi_addr_i,
   input  logic [dmi_pkg::DMI_DATA_W-1:0] dmi_wdata_i,
   output logic                           dmi_rvalid_o,
   output logic [dmi_pkg::DMI_DATA_W-1:0] dmi_rdata_o,
   sba_push_if.producer                   push_mp
);

   logic                           req_q;
   logic                           we_q;
   dmi_pkg::dmi_addr_t             addr_q;
   logic [dmi_pkg::DMI_DATA_W-1:0] wdata_q;

   dmi_pkg::dmi_word_u wr_u;
   dmi_pkg::dmi_word_u rd_u;

   logic [2:0]         sbaccess_q;
   logic               sbautoinc_q;
   logic               sbbusyerror_q;
   logic [2:0]         sberror_q;
   sba_pkg::sba_addr_t sbaddr_q;

   logic sbcs_wr;
   logic addr_wr;
   logic data_wr;
   logic size_ok;
   logic err_set;
   logic push;

   // Request stage, decode happens in the cycle after sampling
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         req_q <= 1'b0;
      end else begin
         req_q <= dmi_req_i;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (dmi_req_i) begin
         we_q    <= dmi_we_i;
         addr_q  <= dmi_addr_i;
         wdata_q <= dmi_wdata_i;
      end
   end

   always_comb begin
      wr_u.raw = wdata_q;
   end

   assign sbcs_wr = req_q & we_q & (addr_q == dmi_pkg::DMI_SBCS);
   assign addr_wr = req_q & we_q & (addr_q == dmi_pkg::DMI_SBADDRESS0);
   assign data_wr = req_q & we_q & (addr_q == dmi_pkg::DMI_SBDATA0);

   assign size_ok = (sbaccess_q == dmi_pkg::SBACCESS_32);
   // Any sticky error blocks new words
   assign err_set = sbbusyerror_q | (sberror_q != 3'd0);
   assign push    = data_wr & size_ok & ~push_mp.full & ~err_set;

   assign push_mp.push  = push;
   assign push_mp.entry = '{addr: sbaddr_q, data: wdata_q};

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sbaccess_q    <= dmi_pkg::SBACCESS_32;
         sbautoinc_q   <= 1'b0;
         sbbusyerror_q <= 1'b0;
         sberror_q     <= 3'd0;
         sbaddr_q      <= '0;
      end else begin
         if (sbcs_wr) begin
            sbaccess_q  <= wr_u.sbcs.sbaccess;
            sbautoinc_q <= wr_u.sbcs.sbautoincrement;
            // Error fields are write-1-to-clear
            if (wr_u.sbcs.sbbusyerror) begin
               sbbusyerror_q <= 1'b0;
            end
            sberror_q <= sberror_q & ~wr_u.sbcs.sberror;
         end
         if (data_wr && !err_set) begin
            if (!size_ok) begin
               sberror_q <= dmi_pkg::SBERR_SIZE;
            end else if (push_mp.full) begin
               sbbusyerror_q <= 1'b1;
            end
         end
         if (addr_wr) begin
            sbaddr_q <= wdata_q;
         end else if (push && sbautoinc_q) begin
            sbaddr_q <= sbaddr_q + sba_pkg::SBA_ADDR_STEP;
         end
      end
   end

   always_comb begin
      rd_u.raw                  = '0;
      rd_u.sbcs.sbversion       = dmi_pkg::SBCS_VERSION;
      rd_u.sbcs.sbbusyerror     = sbbusyerror_q;
      rd_u.sbcs.sbbusy          = ~push_mp.empty;
      rd_u.sbcs.sbaccess        = sbaccess_q;
      rd_u.sbcs.sbautoincrement = sbautoinc_q;
      rd_u.sbcs.sberror         = sberror_q;
      rd_u.sbcs.sbasize         = 7'(sba_pkg::SBA_ADDR_W);
      rd_u.sbcs.sbaccess32      = 1'b1;
   end

   assign dmi_rvalid_o = req_q & ~we_q;

   always_comb begin
      case (addr_q)
         dmi_pkg::DMI_SBCS:       dmi_rdata_o = rd_u.raw;
         dmi_pkg::DMI_SBADDRESS0: dmi_rdata_o = sbaddr_q;
         default:                 dmi_rdata_o = '0;
      endcase
   end

   // A queued word shows up as sbbusy from the next cycle on
   a_busy_after_push: assert property (
      @(posedge clk_sys) disable iff (!rst_n_i)
      push_mp.push |=> !push_mp.empty
   );

endmodule

// File: logic/sba_fifo.sv
// ======================================================================
// Write queue between register block and memory writer
//   Circular buffer of queued address and data entries
//   Occupancy count driving full and empty
// ======================================================================

`timescale 1ns/1ps

module sba_fifo (
   input  logic       clk_sys,
   input  logic       rst_n_i,
   sba_push_if.buffer push_mp,
   sba_pop_if.buffer  pop_mp
);

   sba_pkg::sba_entry_t mem_q [sba_pkg::SBA_FIFO_DEPTH];

   logic [sba_pkg::SBA_PTR_W-1:0] wr_ptr_q;
   logic [sba_pkg::SBA_PTR_W-1:0] rd_ptr_q;
   logic [sba_pkg::SBA_CNT_W-1:0] count_q;

   logic full;
   logic empty;

   always_ff @(posedge clk_sys) begin
      if (push_mp.push) begin
         mem_q[wr_ptr_q] <= push_mp.entry;
      end
   end

   // Pointers wrap on their own, the depth is a power of two
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_mp.push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_mp.pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push_mp.push, pop_mp.pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   assign full  = (count_q == sba_pkg::SBA_CNT_W'(sba_pkg::SBA_FIFO_DEPTH));
   assign empty = (count_q == '0);

   assign push_mp.full  = full;
   assign push_mp.empty = empty;
   assign pop_mp.empty  = empty;
   assign pop_mp.head   = mem_q[rd_ptr_q];

   a_no_overflow: assert property (
      @(posedge clk_sys) disable iff (!rst_n_i)
      push_mp.push |-> !full
   );

   a_no_underflow: assert property (
      @(posedge clk_sys) disable iff (!rst_n_i)
      pop_mp.pop |-> !empty
   );

endmodule

// File: logic/sba_writer.sv
// ======================================================================
// Memory writer
//   Pops the queue head while the memory is not stalling
//   Registered address, data and one-cycle write strobe
// ======================================================================

`timescale 1ns/1ps

module sba_writer (
   input  logic               clk_sys,
   input  logic               rst_n_i,
   input  logic               mem_stall_i,
   sba_pop_if.consumer        pop_mp,
   output logic               mem_we_o,
   output sba_pkg::sba_addr_t mem_addr_o,
   output sba_pkg::sba_data_t mem_wdata_o
);

   logic               pop;
   logic               we_q;
   sba_pkg::sba_addr_t addr_q;
   sba_pkg::sba_data_t data_q;

   assign pop        = ~pop_mp.empty & ~mem_stall_i;
   assign pop_mp.pop = pop;

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         we_q <= 1'b0;
      end else begin
         we_q <= pop;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (pop) begin
         addr_q <= pop_mp.head.addr;
         data_q <= pop_mp.head.data;
      end
   end

   assign mem_we_o    = we_q;
   assign mem_addr_o  = addr_q;
   assign mem_wdata_o = data_q;

   // Every strobe carries a stored address and data word
   a_we_data_known: assert property (
      @(posedge clk_sys) disable iff (!rst_n_i)
      mem_we_o |-> !$isunknown({mem_addr_o, mem_wdata_o})
   );

endmodule

// File: logic/sba_top.sv
// ======================================================================
// System bus loader top level
//   DMI register block feeding the write queue
//   Memory writer draining the queue onto the memory port
// ======================================================================

`timescale 1ns/1ps

module sba_top (
   input  logic                           clk_sys,
   input  logic                           rst_n_i,
   input  logic                           dmi_req_i,
   input  logic                           dmi_we_i,
   input  dmi_pkg::dmi_addr_t             dmi_addr_i,
   input  logic [dmi_pkg::DMI_DATA_W-1:0] dmi_wdata_i,
   output logic                           dmi_rvalid_o,
   output logic [dmi_pkg::DMI_DATA_W-1:0] dmi_rdata_o,
   input  logic                           mem_stall_i,
   output logic                           mem_we_o,
   output sba_pkg::sba_addr_t             mem_addr_o,
   output sba_pkg::sba_data_t             mem_wdata_o
);

   sba_push_if push_if ();
   sba_pop_if  pop_if ();

   // Host side
   dmi_regs u_dmi_regs (
      .clk_sys      (clk_sys),
      .rst_n_i      (rst_n_i),
      .dmi_req_i    (dmi_req_i),
      .dmi_we_i     (dmi_we_i),
      .dmi_addr_i   (dmi_addr_i),
      .dmi_wdata_i  (dmi_wdata_i),
      .dmi_rvalid_o (dmi_rvalid_o),
      .dmi_rdata_o  (dmi_rdata_o),
      .push_mp      (push_if.producer)
   );

   sba_fifo u_sba_fifo (
      .clk_sys (clk_sys),
      .rst_n_i (rst_n_i),
      .push_mp (push_if.buffer),
      .pop_mp  (pop_if.buffer)
   );

   // Memory side
   sba_writer u_sba_writer (
      .clk_sys     (clk_sys),
      .rst_n_i     (rst_n_i),
      .mem_stall_i (mem_stall_i),
      .pop_mp      (pop_if.consumer),
      .mem_we_o    (mem_we_o),
      .mem_addr_o  (mem_addr_o),
      .mem_wdata_o (mem_wdata_o)
   );

endmodule

// File: test/tb_clock.sv
// ======================================================================
// Testbench clock and reset source
//   Free-running clk_sys and an active-low reset held for a few cycles
// ======================================================================

`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 4
) (
   output logic clk_sys,
   output logic rst_n_o
);

   initial begin
      clk_sys = 1'b0;
      forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_sys);
      @(negedge clk_sys);
      rst_n_o = 1'b1;
   end

endmodule

// File: test/tb_sba_top.sv
// ======================================================================
// Testbench of the system bus loader
//   Register access tasks and a model of the expected memory writes
//   Monitor checking every memory write strobe
//   Directed tests, watchdog and final report
// ======================================================================

`timescale 1ns/1ps

module tb_sba_top;

   localparam int CLK_PERIOD    = 20;
   localparam int RESET_CYCLES  = 4;
   // Budget per test: reset, burst, fixed address, back-pressure, size error
   localparam int TEST_CYCLES   = 20 + 80 + 50 + 120 + 80;
   localparam int MARGIN_CYCLES = 200;
   localparam int DRAIN_LIMIT   = 32;
   localparam int POLL_LIMIT    = 10;
   localparam int SBBUSY_BIT    = 21;
   localparam logic [31:0] BURST_BASE = 32'h0000_1000;

   logic               clk_sys;
   logic               rst_n;
   logic               dmi_req;
   logic               dmi_we;
   dmi_pkg::dmi_addr_t dmi_addr;
   logic [31:0]        dmi_wdata;
   logic               dmi_rvalid;
   logic [31:0]        dmi_rdata;
   logic               mem_stall;
   logic               mem_we;
   logic [31:0]        mem_addr;
   logic [31:0]        mem_wdata;

   // Expected writes as {address, data}, oldest first
   logic [63:0] exp_q [$];
   logic [63:0] mon_exp;

   // Model of the loader registers
   logic [2:0]  m_access;
   logic        m_autoinc;
   logic        m_busyerr;
   logic [2:0]  m_sberr;
   logic [31:0] m_addr;
   logic        stall_on;
   int          held;

   int errors;
   int checks;
   int words_seen;

   tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
      .clk_sys (clk_sys),
      .rst_n_o (rst_n)
   );

   sba_top dut0 (
      .clk_sys      (clk_sys),
      .rst_n_i      (rst_n),
      .dmi_req_i    (dmi_req),
      .dmi_we_i     (dmi_we),
      .dmi_addr_i   (dmi_addr),
      .dmi_wdata_i  (dmi_wdata),
      .dmi_rvalid_o (dmi_rvalid),
      .dmi_rdata_o  (dmi_rdata),
      .mem_stall_i  (mem_stall),
      .mem_we_o     (mem_we),
      .mem_addr_o   (mem_addr),
      .mem_wdata_o  (mem_wdata)
   );

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      checks++;
      assert (got === expected) else begin
         errors++;
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      end
   endtask

   // SBCS as laid out by the debug spec, version 1, 32-bit accesses only
   function automatic logic [31:0] sbcs_word(input logic busyerr, input logic busy,
                                             input logic [2:0] access, input logic autoinc,
                                             input logic [2:0] err);
      sbcs_word = {3'd1, 6'd0, busyerr, busy, 1'b0, access, autoinc, 1'b0, err,
                   7'd32, 5'b00100};
   endfunction

   task automatic read_reg(input dmi_pkg::dmi_addr_t addr, output logic [31:0] data);
      @(negedge clk_sys);
      dmi_req   = 1'b1;
      dmi_we    = 1'b0;
      dmi_addr  = addr;
      dmi_wdata = '0;
      @(negedge clk_sys);
      dmi_req = 1'b0;
      check_value("dmi_rvalid_o after read", dmi_rvalid, 1'b1);
      data = dmi_rdata;
      @(negedge clk_sys);
      check_value("dmi_rvalid_o one cycle later", dmi_rvalid, 1'b0);
   endtask

   // Leaves the request raised so that writes can follow back to back
   task automatic write_reg(input dmi_pkg::dmi_addr_t addr, input logic [31:0] data);
      @(negedge clk_sys);
      dmi_req   = 1'b1;
      dmi_we    = 1'b1;
      dmi_addr  = addr;
      dmi_wdata = data;
   endtask

   task automatic release_bus();
      @(negedge clk_sys);
      dmi_req = 1'b0;
      check_value("dmi_rvalid_o after write", dmi_rvalid, 1'b0);
   endtask

   task automatic write_sbcs(input logic [2:0] access, input logic autoinc,
                             input logic clr_busyerr, input logic [2:0] clr_err);
      write_reg(dmi_pkg::DMI_SBCS, sbcs_word(clr_busyerr, 1'b0, access, autoinc, clr_err));
      m_access  = access;
      m_autoinc = autoinc;
      if (clr_busyerr) begin
         m_busyerr = 1'b0;
      end
      m_sberr = m_sberr & ~clr_err;
   endtask

   task automatic write_address(input logic [31:0] addr);
      write_reg(dmi_pkg::DMI_SBADDRESS0, addr);
      m_addr = addr;
   endtask

   task automatic write_word();
      logic [31:0] data;
      data = $urandom();
      // Sticky errors refuse the word, then size, then a full queue
      if (!m_busyerr && m_sberr == 3'd0) begin
         if (m_access != 3'd2) begin
            m_sberr = 3'd4;
         end else if (stall_on && held >= 4) begin
            m_busyerr = 1'b1;
         end else begin
            exp_q.push_back({m_addr, data});
            if (stall_on) begin
               held++;
            end
            if (m_autoinc) begin
               m_addr = m_addr + 32'd4;
            end
         end
      end
      write_reg(dmi_pkg::DMI_SBDATA0, data);
   endtask

   task automatic set_stall(input logic on);
      @(negedge clk_sys);
      mem_stall = on;
      stall_on  = on;
      held      = 0;
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
         @(negedge clk_sys);
         n++;
      end
      checks++;
      assert (exp_q.size() == 0) else begin
         errors++;
         $display("%0d expected memory writes still missing after %0d cycles",
                  exp_q.size(), DRAIN_LIMIT);
      end
   endtask

   task automatic poll_not_busy();
      logic [31:0] rd;
      int          n;
      n = 0;
      read_reg(dmi_pkg::DMI_SBCS, rd);
      while (rd[SBBUSY_BIT] && n < POLL_LIMIT) begin
         read_reg(dmi_pkg::DMI_SBCS, rd);
         n++;
      end
      checks++;
      assert (!rd[SBBUSY_BIT]) else begin
         errors++;
         $display("sbbusy still set after %0d SBCS reads", POLL_LIMIT);
      end
   endtask

   task automatic expect_sbcs(input logic busy);
      logic [31:0] rd;
      read_reg(dmi_pkg::DMI_SBCS, rd);
      check_value("SBCS", rd, sbcs_word(m_busyerr, busy, m_access, m_autoinc, m_sberr));
   endtask

   task automatic expect_address();
      logic [31:0] rd;
      read_reg(dmi_pkg::DMI_SBADDRESS0, rd);
      check_value("SBAddress0", rd, m_addr);
   endtask

   task automatic reset_readback();
      check_value("mem_we_o after reset", mem_we, 1'b0);
      check_value("dmi_rvalid_o after reset", dmi_rvalid, 1'b0);
      expect_sbcs(1'b0);
      expect_address();
   endtask

   task automatic autoinc_burst();
      time         t_req;
      int          n;
      logic [31:0] rd;
      write_sbcs(3'd2, 1'b1, 1'b0, 3'd0);
      write_address(BURST_BASE);
      release_bus();
      // Single word into an idle loader for the latency
      write_word();
      @(posedge clk_sys);
      t_req = $time;
      release_bus();
      n = 0;
      while (!mem_we && n < DRAIN_LIMIT) begin
         @(negedge clk_sys);
         n++;
      end
      check_value("cycles from request to mem_we_o",
                  ($time - CLK_PERIOD / 2 - t_req) / CLK_PERIOD, 2);
      wait_drained();
      repeat (7) write_word();
      release_bus();
      wait_drained();
      read_reg(dmi_pkg::DMI_SBADDRESS0, rd);
      check_value("SBAddress0 after burst", rd, BURST_BASE + 32'd32);
      expect_sbcs(1'b0);
   endtask

   task automatic fixed_address();
      write_sbcs(3'd2, 1'b0, 1'b0, 3'd0);
      write_address(32'h0000_2040);
      repeat (6) write_word();
      release_bus();
      wait_drained();
      expect_address();
      expect_sbcs(1'b0);
   endtask

   task automatic back_pressure();
      int seen;
      write_sbcs(3'd2, 1'b1, 1'b0, 3'd0);
      write_address(32'h0000_3000);
      release_bus();
      set_stall(1'b1);
      seen = words_seen;
      repeat (5) write_word();
      release_bus();
      expect_sbcs(1'b1);
      expect_address();
      check_value("memory writes while stalled", words_seen - seen, 0);
      set_stall(1'b0);
      wait_drained();
      repeat (4) @(negedge clk_sys);
      check_value("memory writes after stall", words_seen - seen, 4);
      poll_not_busy();
      expect_sbcs(1'b0);
      write_sbcs(3'd2, 1'b1, 1'b1, 3'd0);
      release_bus();
      expect_sbcs(1'b0);
   endtask

   task automatic size_error();
      int seen;
      write_sbcs(3'd1, 1'b0, 1'b0, 3'd0);
      write_address(32'h0000_4000);
      seen = words_seen;
      write_word();
      release_bus();
      expect_sbcs(1'b0);
      // Size restored, error still pending
      write_sbcs(3'd2, 1'b0, 1'b0, 3'd0);
      write_word();
      release_bus();
      expect_sbcs(1'b0);
      repeat (4) @(negedge clk_sys);
      check_value("memory writes under size error", words_seen - seen, 0);
      write_sbcs(3'd2, 1'b0, 1'b0, 3'b111);
      write_word();
      release_bus();
      wait_drained();
      repeat (2) @(negedge clk_sys);
      check_value("memory writes after clearing", words_seen - seen, 1);
      expect_sbcs(1'b0);
   endtask

   // Outputs settle after the rising edge, sampled on the falling one
   always @(negedge clk_sys) begin
      if (rst_n && mem_we) begin
         words_seen++;
         checks++;
         assert (exp_q.size() != 0) else begin
            errors++;
            $display("error at %0t ns: memory write to %h with no word expected",
                     $time, mem_addr);
         end
         if (exp_q.size() != 0) begin
            mon_exp = exp_q.pop_front();
            check_value("mem_addr_o", mem_addr, mon_exp[63:32]);
            check_value("mem_wdata_o", mem_wdata, mon_exp[31:0]);
         end
      end
   end

   initial begin
      #(CLK_PERIOD * (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES));
      $display("watchdog expired, the tests did not finish in time");
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      dmi_req    = 1'b0;
      dmi_we     = 1'b0;
      dmi_addr   = '0;
      dmi_wdata  = '0;
      mem_stall  = 1'b0;
      m_access   = 3'd2;
      m_autoinc  = 1'b0;
      m_busyerr  = 1'b0;
      m_sberr    = 3'd0;
      m_addr     = '0;
      stall_on   = 1'b0;
      held       = 0;
      errors     = 0;
      checks     = 0;
      words_seen = 0;
      void'($urandom(32'hc724));
      @(posedge rst_n);
      @(negedge clk_sys);
      reset_readback();
      autoinc_burst();
      fixed_address();
      back_pressure();
      size_error();
      $display("tests done: %0d checks, %0d errors, %0d memory writes",
               checks, errors, words_seen);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: filelist.f
logic/dmi_pkg.sv
logic/sba_pkg.sv
logic/sba_push_if.sv
logic/sba_pop_if.sv
logic/dmi_regs.sv
logic/sba_fifo.sv
logic/sba_writer.sv
logic/sba_top.sv
test/tb_clock.sv
test/tb_sba_top.sv
